//--- vga_params.svh
`ifndef VGA_PARAMS_SVH
`define VGA_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// raster timing, 640x480 at 60 Hz on a 25 MHz pixel clock
////////////////////////////////////////////////////////////////////////////

`define VGA_H_TOTAL   800      // clocks per line
`define VGA_V_TOTAL   525      // lines per frame
`define VGA_H_SYNC    96       // hs low for h_count 0..95
`define VGA_V_SYNC    2        // vs low for v_count 0..1
`define VGA_H_START   143      // first visible column count
`define VGA_H_END     783      // one past the last visible column
`define VGA_V_START   35       // first visible line count
`define VGA_V_END     515      // one past the last visible line

////////////////////////////////////////////////////////////////////////////
// overlay layers and configuration address
////////////////////////////////////////////////////////////////////////////

`define VGA_N_LAYERS  4        // power of two, up to 8
`define VGA_LAYER_W   $clog2(`VGA_N_LAYERS)
`define VGA_FIELD_W   3        // low part of cfg_addr
`define VGA_ADDR_W    (`VGA_LAYER_W + `VGA_FIELD_W)
`define VGA_RGB_W     12       // rgb444

`endif

//--- vga_timing_pkg.sv
package vga_timing_pkg;

    // raw counter value, horizontal or vertical
    // wide enough for 0..799
    typedef logic [9:0] count_t;

    // visible pixel row
    // 0..479 fits in 9 bits
    typedef logic [8:0] row_t;

    // visible pixel column
    // 0..639, needs the full 10 bits
    typedef logic [9:0] col_t;

endpackage

//--- vga_layer_pkg.sv
`include "vga_params.svh"

package vga_layer_pkg;

    typedef logic [`VGA_RGB_W-1:0]   rgb_t;        // {r[3:0], g[3:0], b[3:0]}
    typedef logic [`VGA_LAYER_W-1:0] layer_idx_t;  // layer part of cfg_addr
    typedef logic [`VGA_FIELD_W-1:0] field_t;      // field part of cfg_addr
    typedef logic [`VGA_RGB_W-1:0]   cfg_data_t;   // one config word

    ////////////////////////////////////////////////////////////////////////
    // field codes
    ////////////////////////////////////////////////////////////////////////

    localparam field_t FLD_X0     = 3'd0;  // left bound, inclusive
    localparam field_t FLD_X1     = 3'd1;  // right bound, inclusive
    localparam field_t FLD_Y0     = 3'd2;  // top bound
    localparam field_t FLD_Y1     = 3'd3;  // bottom bound
    localparam field_t FLD_COLOR  = 3'd4;  // layer fill color
    localparam field_t FLD_ENABLE = 3'd5;  // bit 0 only
    localparam field_t FLD_BG     = 3'd6;  // background, layer bits ignored

    // code 7 is unused and dropped by the decoder

endpackage

//--- vgac.sv
`timescale 1ns/1ps
`include "vga_params.svh"

module vgac (
    input                        vga_clk,   // 25 MHz pixel clock
    input                        clrn,
    output vga_timing_pkg::row_t row_addr,  // 0..479 in the visible area
    output vga_timing_pkg::col_t col_addr,  // 0..639 in the visible area
    output logic                 rdn,       // active low read strobe
    output logic                 hs,
    output logic                 vs
);
    import vga_timing_pkg::*;

    count_t h_count;                        // 0..799
    count_t v_count;                        // 0..524
    count_t row;
    count_t col;
    logic   h_sync;
    logic   v_sync;
    logic   read;

    // horizontal counter
    always_ff @(posedge vga_clk or negedge clrn) begin
        if (!clrn) begin
            h_count <= '0;
        end else if (h_count == count_t'(`VGA_H_TOTAL - 1)) begin
            h_count <= '0;                  // end of line
        end else begin
            h_count <= h_count + count_t'(1);
        end
    end

    // vertical counter, steps once per line
    always_ff @(posedge vga_clk or negedge clrn) begin
        if (!clrn) begin
            v_count <= '0;
        end else if (h_count == count_t'(`VGA_H_TOTAL - 1)) begin
            if (v_count == count_t'(`VGA_V_TOTAL - 1)) begin
                v_count <= '0;              // end of frame
            end else begin
                v_count <= v_count + count_t'(1);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // levels decoded from the counters, registered below
    ////////////////////////////////////////////////////////////////////////

    assign row    = v_count - count_t'(`VGA_V_START);
    assign col    = h_count - count_t'(`VGA_H_START);
    assign h_sync = (h_count >= count_t'(`VGA_H_SYNC));     // 96..799
    assign v_sync = (v_count >= count_t'(`VGA_V_SYNC));     // 2..524
    assign read   = (h_count >= count_t'(`VGA_H_START)) &&  // 143..782
                    (h_count <  count_t'(`VGA_H_END))   &&
                    (v_count >= count_t'(`VGA_V_START)) &&  // 35..514
                    (v_count <  count_t'(`VGA_V_END));

    // pixel position, garbage outside the visible window
    always_ff @(posedge vga_clk) begin
        row_addr <= row_t'(row);            // drop the top bit
        col_addr <= col;
    end

    // strobes, reset to what a zero count produces
    always_ff @(posedge vga_clk or negedge clrn) begin
        if (!clrn) begin
            rdn <= 1'b1;
            hs  <= 1'b0;
            vs  <= 1'b0;
        end else begin
            rdn <= ~read;
            hs  <= h_sync;
            vs  <= v_sync;
        end
    end

endmodule

//--- layer_cfg_decoder.sv
`timescale 1ns/1ps
`include "vga_params.svh"

module layer_cfg_decoder (
    input                             vga_clk,
    input                             clrn,
    input                             cfg_we,     // one cycle per write
    input        [`VGA_ADDR_W-1:0]    cfg_addr,   // {layer, field}
    input  vga_layer_pkg::cfg_data_t  cfg_data,
    output logic [`VGA_N_LAYERS-1:0]  layer_wr,   // one-hot write pulse
    output logic                      bg_wr,      // background write pulse
    output vga_layer_pkg::field_t     wr_field,
    output vga_layer_pkg::cfg_data_t  wr_data
);
    import vga_layer_pkg::*;

    layer_idx_t                 layer;
    field_t                     field;
    logic [`VGA_N_LAYERS-1:0]   layer_sel;
    logic                       is_layer_fld;

    assign layer        = cfg_addr[`VGA_ADDR_W-1:`VGA_FIELD_W];
    assign field        = cfg_addr[`VGA_FIELD_W-1:0];
    assign is_layer_fld = (field <= FLD_ENABLE);    // codes 0..5

    // one-hot select of the addressed layer
    always_comb begin
        layer_sel = '0;
        for (int i = 0; i < `VGA_N_LAYERS; i++) begin
            if (layer == layer_idx_t'(i)) begin
                layer_sel[i] = 1'b1;
            end
        end
    end

    // write pulses
    always_ff @(posedge vga_clk or negedge clrn) begin
        if (!clrn) begin
            layer_wr <= '0;
            bg_wr    <= 1'b0;
        end else begin
            layer_wr <= (cfg_we && is_layer_fld) ? layer_sel : '0;
            bg_wr    <= cfg_we && (field == FLD_BG);  // code 7 falls through
        end
    end

    // field and data ride along with the pulse
    always_ff @(posedge vga_clk) begin
        wr_field <= field;
        wr_data  <= cfg_data;
    end

endmodule

//--- box_layer.sv
`timescale 1ns/1ps

module box_layer (
    input                             vga_clk,
    input                             clrn,
    input                             wr,         // this layer is written
    input  vga_layer_pkg::field_t     wr_field,
    input  vga_layer_pkg::cfg_data_t  wr_data,
    input  vga_timing_pkg::row_t      row_addr,
    input  vga_timing_pkg::col_t      col_addr,
    input                             rdn,        // low on visible pixels
    output logic                      hit,        // pixel inside the box
    output vga_layer_pkg::rgb_t       color       // fill color
);
    import vga_timing_pkg::*;
    import vga_layer_pkg::*;

    col_t x0;                                     // bounds, all inclusive
    col_t x1;
    row_t y0;
    row_t y1;
    logic enable;
    logic in_x;
    logic in_y;

    ////////////////////////////////////////////////////////////////////////
    // layer registers
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge vga_clk or negedge clrn) begin
        if (!clrn) begin
            x0     <= '0;
            x1     <= '0;
            y0     <= '0;
            y1     <= '0;
            color  <= '0;
            enable <= 1'b0;                       // layer starts hidden
        end else if (wr) begin
            case (wr_field)
                FLD_X0:     x0     <= col_t'(wr_data);
                FLD_X1:     x1     <= col_t'(wr_data);
                FLD_Y0:     y0     <= row_t'(wr_data);
                FLD_Y1:     y1     <= row_t'(wr_data);
                FLD_COLOR:  color  <= rgb_t'(wr_data);
                FLD_ENABLE: enable <= wr_data[0];
                default:    ;                     // decoder never sends others here
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // rectangle test
    ////////////////////////////////////////////////////////////////////////

    // an inverted range can never satisfy both compares
    assign in_x = (col_addr >= x0) && (col_addr <= x1);
    assign in_y = (row_addr >= y0) && (row_addr <= y1);

    always_ff @(posedge vga_clk or negedge clrn) begin
        if (!clrn) begin
            hit <= 1'b0;
        end else begin
            hit <= enable && !rdn && in_x && in_y;
        end
    end

endmodule

//--- layer_mixer.sv
`timescale 1ns/1ps
`include "vga_params.svh"

module layer_mixer (
    input                                              vga_clk,
    input                                              clrn,
    input        [`VGA_N_LAYERS-1:0]                   hit,
    input  vga_layer_pkg::rgb_t [`VGA_N_LAYERS-1:0]    layer_color,
    input                                              bg_wr,
    input  vga_layer_pkg::cfg_data_t                   bg_data,
    input                                              rdn,
    input                                              hs,
    input                                              vs,
    output vga_layer_pkg::rgb_t                        vga_rgb,
    output logic                                       vga_de,
    output logic                                       vga_hs,
    output logic                                       vga_vs
);
    import vga_layer_pkg::*;

    rgb_t bg_color;                 // shown where no layer hits
    rgb_t pick;
    logic rd_d1;                    // first stage, lines up with hit
    logic hs_d1;
    logic vs_d1;

    // background register
    always_ff @(posedge vga_clk or negedge clrn) begin
        if (!clrn) begin
            bg_color <= '0;
        end else if (bg_wr) begin
            bg_color <= rgb_t'(bg_data);
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // priority select, lowest index wins
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        pick = bg_color;
        for (int i = `VGA_N_LAYERS - 1; i >= 0; i--) begin
            if (hit[i]) begin
                pick = layer_color[i];  // later (lower) index overrides
            end
        end
    end

    // two-stage sync and read pipeline, color on the second stage
    always_ff @(posedge vga_clk or negedge clrn) begin
        if (!clrn) begin
            rd_d1   <= 1'b0;
            hs_d1   <= 1'b0;
            vs_d1   <= 1'b0;
            vga_de  <= 1'b0;
            vga_hs  <= 1'b0;
            vga_vs  <= 1'b0;
            vga_rgb <= '0;
        end else begin
            rd_d1   <= ~rdn;
            hs_d1   <= hs;
            vs_d1   <= vs;
            vga_de  <= rd_d1;
            vga_hs  <= hs_d1;
            vga_vs  <= vs_d1;
            vga_rgb <= rd_d1 ? pick : '0;   // black in blanking
        end
    end

endmodule

//--- vga_overlay_top.sv
`timescale 1ns/1ps
`include "vga_params.svh"

module vga_overlay_top (
    input                              vga_clk,
    input                              clrn,
    input                              cfg_we,
    input        [`VGA_ADDR_W-1:0]     cfg_addr,
    input  vga_layer_pkg::cfg_data_t   cfg_data,
    output logic                       vga_hs,
    output logic                       vga_vs,
    output logic                       vga_de,
    output vga_layer_pkg::rgb_t        vga_rgb
);
    import vga_timing_pkg::*;
    import vga_layer_pkg::*;

    // raster
    row_t                       row_addr;
    col_t                       col_addr;
    logic                       rdn;
    logic                       hs;
    logic                       vs;

    // configuration
    logic [`VGA_N_LAYERS-1:0]   layer_wr;
    logic                       bg_wr;
    field_t                     wr_field;
    cfg_data_t                  wr_data;

    // layer results
    logic [`VGA_N_LAYERS-1:0]   hit;
    rgb_t [`VGA_N_LAYERS-1:0]   layer_color;

    ////////////////////////////////////////////////////////////////////////
    // timing and config front end
    ////////////////////////////////////////////////////////////////////////

    vgac i_vgac (
        .vga_clk  (vga_clk),
        .clrn     (clrn),
        .row_addr (row_addr),
        .col_addr (col_addr),
        .rdn      (rdn),
        .hs       (hs),
        .vs       (vs)
    );

    layer_cfg_decoder i_layer_cfg_decoder (
        .vga_clk  (vga_clk),
        .clrn     (clrn),
        .cfg_we   (cfg_we),
        .cfg_addr (cfg_addr),
        .cfg_data (cfg_data),
        .layer_wr (layer_wr),
        .bg_wr    (bg_wr),
        .wr_field (wr_field),
        .wr_data  (wr_data)
    );

    // one box per layer
    for (genvar g = 0; g < `VGA_N_LAYERS; g++) begin : g_layer
        box_layer i_box_layer (
            .vga_clk  (vga_clk),
            .clrn     (clrn),
            .wr       (layer_wr[g]),
            .wr_field (wr_field),
            .wr_data  (wr_data),
            .row_addr (row_addr),
            .col_addr (col_addr),
            .rdn      (rdn),
            .hit      (hit[g]),
            .color    (layer_color[g])
        );
    end

    layer_mixer i_layer_mixer (
        .vga_clk     (vga_clk),
        .clrn        (clrn),
        .hit         (hit),
        .layer_color (layer_color),
        .bg_wr       (bg_wr),
        .bg_data     (wr_data),     // shared data bus from the decoder
        .rdn         (rdn),
        .hs          (hs),
        .vs          (vs),
        .vga_rgb     (vga_rgb),
        .vga_de      (vga_de),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs)
    );

endmodule

//--- vga_overlay_assertions.sv
`timescale 1ns/1ps
`include "vga_params.svh"

module vga_overlay_assertions (
    input                            vga_clk,
    input                            clrn,
    input                            cfg_we,
    input  [`VGA_N_LAYERS-1:0]       layer_wr,   // decoder pulses
    input                            bg_wr,
    input                            vga_de,
    input                            vga_hs,
    input                            vga_vs,
    input  vga_layer_pkg::rgb_t      vga_rgb
);
    int assert_errs = 0;                         // failure count, read from the testbench

    ////////////////////////////////////////////////////////////////////////////
    // output side
    ////////////////////////////////////////////////////////////////////////////

    a_blank_black: assert property (@(posedge vga_clk) disable iff (!clrn)
        !vga_de |-> vga_rgb == '0)
        else begin
            $error("vga_rgb is not black while vga_de is low");
            assert_errs++;
        end

    // visible pixels never overlap a sync pulse
    a_de_outside_sync: assert property (@(posedge vga_clk) disable iff (!clrn)
        vga_de |-> vga_hs && vga_vs)
        else begin
            $error("vga_de is high during a sync pulse");
            assert_errs++;
        end

    ////////////////////////////////////////////////////////////////////////////
    // decoder side
    ////////////////////////////////////////////////////////////////////////////

    a_one_pulse: assert property (@(posedge vga_clk) disable iff (!clrn)
        $onehot0({layer_wr, bg_wr}))             // at most one target per write
        else begin
            $error("more than one decoder write pulse at once");
            assert_errs++;
        end

    a_pulse_after_we: assert property (@(posedge vga_clk) disable iff (!clrn)
        (|layer_wr || bg_wr) |-> $past(cfg_we))  // no pulse without a write
        else begin
            $error("decoder pulse without a write one cycle before");
            assert_errs++;
        end

endmodule

bind vga_overlay_top vga_overlay_assertions i_vga_overlay_assertions (
    .vga_clk  (vga_clk),
    .clrn     (clrn),
    .cfg_we   (cfg_we),
    .layer_wr (layer_wr),
    .bg_wr    (bg_wr),
    .vga_de   (vga_de),
    .vga_hs   (vga_hs),
    .vga_vs   (vga_vs),
    .vga_rgb  (vga_rgb)
);

//--- tb_vga_overlay.sv
`timescale 1ns/1ps
`include "vga_params.svh"

module tb_vga_overlay;
    import vga_layer_pkg::*;

    localparam int N_CFG      = 26;
    localparam int N_FIXED    = 14;
    localparam int N_RAND     = 12;
    localparam int N_PROBE    = N_FIXED + N_RAND;
    localparam int FRAME_CLKS = `VGA_H_TOTAL * `VGA_V_TOTAL;

    logic                   vga_clk;
    logic                   clrn;
    logic                   cfg_we;
    logic [`VGA_ADDR_W-1:0] cfg_addr;
    cfg_data_t              cfg_data;
    logic                   vga_hs;
    logic                   vga_vs;
    logic                   vga_de;
    rgb_t                   vga_rgb;

    // {layer, field, data}, applied in order
    logic [16:0] cfg_tbl [N_CFG] = '{
        {2'd0, FLD_BG, 12'h123},                 // background
        {2'd0, FLD_X0, 12'd100}, {2'd0, FLD_X1, 12'd199}, {2'd0, FLD_Y0, 12'd50},
        {2'd0, FLD_Y1, 12'd149}, {2'd0, FLD_COLOR, 12'hf00}, {2'd0, FLD_ENABLE, 12'h001},
        {2'd2, FLD_X0, 12'd150}, {2'd2, FLD_X1, 12'd299}, {2'd2, FLD_Y0, 12'd100},
        {2'd2, FLD_Y1, 12'd199}, {2'd2, FLD_COLOR, 12'h0f0}, {2'd2, FLD_ENABLE, 12'h001},
        {2'd1, FLD_X0, 12'd400}, {2'd1, FLD_X1, 12'd450}, {2'd1, FLD_Y0, 12'd300},
        {2'd1, FLD_Y1, 12'd350}, {2'd1, FLD_COLOR, 12'h00f}, {2'd1, FLD_ENABLE, 12'h000},
        {2'd3, FLD_X0, 12'd500}, {2'd3, FLD_X1, 12'd400}, {2'd3, FLD_Y0, 12'd10},
        {2'd3, FLD_Y1, 12'd400}, {2'd3, FLD_COLOR, 12'hfff}, {2'd3, FLD_ENABLE, 12'h001},
        {2'd1, 3'd7, 12'habc}                    // unused code
    };

    // {row, col, expected color}
    logic [30:0] probe_tbl [N_FIXED] = '{
        {9'd50, 10'd100, 12'hf00}, {9'd50, 10'd199, 12'hf00}, {9'd149, 10'd100, 12'hf00},
        {9'd149, 10'd199, 12'hf00},                          // layer 0 corners
        {9'd49, 10'd100, 12'h123}, {9'd50, 10'd99, 12'h123}, {9'd150, 10'd100, 12'h123},
        {9'd60, 10'd200, 12'h123},                           // one pixel outside
        {9'd120, 10'd175, 12'hf00}, {9'd180, 10'd250, 12'h0f0}, {9'd199, 10'd299, 12'h0f0},
        {9'd200, 10'd299, 12'h123},                          // overlap and layer 2 alone
        {9'd325, 10'd425, 12'h123}, {9'd200, 10'd450, 12'h123}  // disabled, empty box
    };

    int   m_x0 [`VGA_N_LAYERS] = '{default: 0};   // reference model registers
    int   m_x1 [`VGA_N_LAYERS] = '{default: 0};
    int   m_y0 [`VGA_N_LAYERS] = '{default: 0};
    int   m_y1 [`VGA_N_LAYERS] = '{default: 0};
    int   m_col [`VGA_N_LAYERS] = '{default: 0};
    int   m_en [`VGA_N_LAYERS] = '{default: 0};
    int   m_bg = 0;

    int   p_row [N_PROBE];
    int   p_col [N_PROBE];
    int   p_exp [N_PROBE];
    int   p_got [N_PROBE];
    bit   p_seen [N_PROBE] = '{default: 1'b0};

    int   frame = 0;                             // vs rising edges seen
    int   line = 0;                              // visible line within the frame
    int   pix = 0;                               // visible pixel within the line
    int   hs_low = 0;
    int   vs_low = 0;
    int   frame_clks = 0;
    int   sync_errs = 0;
    int   blank_errs = 0;
    logic prev_de = 1'b0;
    logic prev_hs = 1'b0;
    logic prev_vs = 1'b0;
    int   n_pass = 0;
    int   n_fail = 0;
    logic [31:0] lfsr = 32'hbff8a930;

    vga_overlay_top i_vga_overlay_top (
        .vga_clk  (vga_clk),
        .clrn     (clrn),
        .cfg_we   (cfg_we),
        .cfg_addr (cfg_addr),
        .cfg_data (cfg_data),
        .vga_hs   (vga_hs),
        .vga_vs   (vga_vs),
        .vga_de   (vga_de),
        .vga_rgb  (vga_rgb)
    );

    initial vga_clk = 1'b0;
    always #5 vga_clk = ~vga_clk;                // 100 MHz sim clock, period 10 ns

    // galois lfsr, one step per bit taken
    function automatic int lfsr_bits(input int n);
        int v;
        v = 0;
        for (int k = 0; k < n; k++) begin
            v = (v << 1) | lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // replay the config table into the model
    task automatic build_model();
        int layer;
        int field;
        int data;
        for (int i = 0; i < N_CFG; i++) begin
            layer = cfg_tbl[i][16:15];
            field = cfg_tbl[i][14:12];
            data  = cfg_tbl[i][11:0];
            case (field)
                0: m_x0[layer] = data % 1024;    // columns hold 10 bits
                1: m_x1[layer] = data % 1024;
                2: m_y0[layer] = data % 512;     // rows hold 9 bits
                3: m_y1[layer] = data % 512;
                4: m_col[layer] = data;
                5: m_en[layer] = data % 2;
                6: m_bg = data;                  // layer bits ignored
                default: ;                       // code 7 changes nothing
            endcase
        end
    endtask

    function automatic int ref_color(input int row, input int col);
        for (int l = 0; l < `VGA_N_LAYERS; l++) begin
            if (m_en[l] == 1 && col >= m_x0[l] && col <= m_x1[l] &&
                row >= m_y0[l] && row <= m_y1[l]) begin
                return m_col[l];                 // first hit wins
            end
        end
        return m_bg;
    endfunction

    task automatic expect_equal(input string sig, input int got, input int exp,
                                inout int errs);
        if (got != exp) begin
            $display("FAILED %s: got %0h expected %0h", sig, got, exp);
            errs++;
        end
    endtask

    task automatic report_test(input string name, input int errs);
        if (errs == 0) begin
            n_pass++;
            $display("test %s: passed", name);
        end else begin
            n_fail++;
            $display("test %s: failed with %0d errors", name, errs);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // raster tracking, sampled on the falling edge
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge vga_clk) begin
        if (clrn) begin
            if (!vga_de && vga_rgb != '0) begin
                blank_errs++;
                if (blank_errs <= 4) $display("FAILED vga_rgb in blanking: got %0h expected 0",
                                              vga_rgb);
            end
            if (vga_vs && !prev_vs) begin        // new frame
                if (frame == 2) begin
                    expect_equal("frame clocks", frame_clks, FRAME_CLKS, sync_errs);
                    expect_equal("vga_vs low clocks", vs_low, `VGA_V_SYNC * `VGA_H_TOTAL,
                                 sync_errs);
                    expect_equal("vga_de lines", line, `VGA_V_END - `VGA_V_START, sync_errs);
                end
                frame++;
                line = 0;
                pix = 0;
                frame_clks = 0;
                vs_low = 0;
            end
            frame_clks++;
            if (!vga_vs) vs_low++;
            if (!vga_hs) hs_low++;
            if (vga_hs && !prev_hs) begin        // end of hs pulse
                if (frame == 2) expect_equal("vga_hs low clocks", hs_low, `VGA_H_SYNC,
                                             sync_errs);
                hs_low = 0;
            end
            if (vga_de) begin
                if (frame == 2) begin
                    for (int i = 0; i < N_PROBE; i++) begin
                        if (p_row[i] == line && p_col[i] == pix) begin
                            p_got[i] = vga_rgb;
                            p_seen[i] = 1'b1;
                        end
                    end
                end
                pix++;
            end else if (prev_de) begin          // line done
                if (frame == 2) expect_equal("vga_de clocks per line", pix,
                                             `VGA_H_END - `VGA_H_START, sync_errs);
                line++;
                pix = 0;
            end
            prev_de = vga_de;
            prev_hs = vga_hs;
            prev_vs = vga_vs;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int errs;
        clrn     = 1'b0;
        cfg_we   = 1'b0;
        cfg_addr = '0;
        cfg_data = '0;
        errs     = 0;
        repeat (5) @(posedge vga_clk);
        #1;
        expect_equal("vga_rgb", vga_rgb, 0, errs);   // everything low in reset
        expect_equal("vga_de", vga_de, 0, errs);
        expect_equal("vga_hs", vga_hs, 0, errs);
        expect_equal("vga_vs", vga_vs, 0, errs);
        report_test("reset state", errs);
        clrn = 1'b1;
        for (int i = 0; i < N_CFG; i++) begin    // first frame blanking
            @(posedge vga_clk);
            #1;
            cfg_we   = 1'b1;
            cfg_addr = cfg_tbl[i][16:12];
            cfg_data = cfg_tbl[i][11:0];
        end
        @(posedge vga_clk);
        #1;
        cfg_we = 1'b0;
        build_model();
        for (int i = 0; i < N_FIXED; i++) begin
            p_row[i] = probe_tbl[i][30:22];
            p_col[i] = probe_tbl[i][21:12];
            p_exp[i] = probe_tbl[i][11:0];
        end
        for (int i = N_FIXED; i < N_PROBE; i++) begin
            p_row[i] = lfsr_bits(9) % 480;
            p_col[i] = lfsr_bits(10) % 640;
            p_exp[i] = ref_color(p_row[i], p_col[i]);
        end
        wait (frame == 3);                       // second frame fully seen
        report_test("sync shape", sync_errs);
        report_test("blanking", blank_errs);
        for (int i = 0; i < N_PROBE; i++) begin
            errs = 0;
            if (!p_seen[i]) begin
                $display("probe %0d at row %0d col %0d was never displayed", i,
                         p_row[i], p_col[i]);
                errs++;
            end else begin
                expect_equal("vga_rgb", p_got[i], p_exp[i], errs);
            end
            report_test($sformatf("probe %0d row %0d col %0d", i, p_row[i], p_col[i]), errs);
        end
        $display("tests passed %0d, failed %0d, assertion failures %0d", n_pass, n_fail,
                 i_vga_overlay_top.i_vga_overlay_assertions.assert_errs);
        if (n_fail == 0 && i_vga_overlay_top.i_vga_overlay_assertions.assert_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // three frames plus margin
    initial begin
        #(3 * FRAME_CLKS * 10 + 50000);
        $display("timeout: the end of the second frame was never reached");
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- build.f
+incdir+.
vga_timing_pkg.sv
vga_layer_pkg.sv
vgac.sv
layer_cfg_decoder.sv
box_layer.sv
layer_mixer.sv
vga_overlay_top.sv
vga_overlay_assertions.sv
tb_vga_overlay.sv
